// File: hdl/muldiv_defs.svh
/*
 * width, iteration and register map macros for the multiply/divide unit
 */

`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// --------------------------------------------------
// datapath sizing
// --------------------------------------------------

// operand width, results are twice this
`define MULDIV_XLEN 32
// one iteration per operand bit
`define MULDIV_ITERS 32
// enough bits to count ITERS-1 down to zero
`define MULDIV_CNT_W 5

// --------------------------------------------------
// wishbone register map, byte addresses
// --------------------------------------------------

`define MULDIV_ADDR_A      8'h00
`define MULDIV_ADDR_B      8'h04
`define MULDIV_ADDR_CMD    8'h08
`define MULDIV_ADDR_STATUS 8'h0C
`define MULDIV_ADDR_RES_LO 8'h10
`define MULDIV_ADDR_RES_HI 8'h14

`endif

// File: hdl/muldiv_pkg.sv
/*
 * shared types: function code, request/response, datapath command,
 * status and wishbone bus structs
 */
`default_nettype none

`include "muldiv_defs.svh"

package muldiv_pkg;

  // function code, lives in CMD[1:0]
  typedef enum logic [1:0] {
    FN_DIV  = 2'd0,
    FN_DIVU = 2'd1,
    FN_MUL  = 2'd2,
    FN_MULU = 2'd3
  } muldiv_fn_e;

  // operation handed from the register block to the datapaths
  typedef struct packed {
    muldiv_fn_e               fn;
    logic [`MULDIV_XLEN-1:0]  a;
    logic [`MULDIV_XLEN-1:0]  b;
  } muldiv_req_t;

  // div: hi = remainder, lo = quotient
  // mul: hi/lo = product halves
  typedef struct packed {
    logic [`MULDIV_XLEN-1:0]  hi;
    logic [`MULDIV_XLEN-1:0]  lo;
  } muldiv_resp_t;

  // per-cycle strobes from the sequencer
  typedef struct packed {
    logic load;
    logic step;
    logic fix;
  } dpath_cmd_t;

  // reads back in STATUS[1:0]
  typedef struct packed {
    logic busy;
    logic done;
  } status_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wb_m2s_t;

  // wishbone classic, slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_s2m_t;

endpackage

`default_nettype wire

// File: hdl/muldiv_wb_regs.sv
/*
 * wishbone classic slave: operand, command, status and result registers,
 * start pulse generation and request capture
 */
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_wb_regs (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::wb_m2s_t      wb_in,
  output muldiv_pkg::wb_s2m_t      wb_out,
  input  muldiv_pkg::status_t      status,
  input  muldiv_pkg::muldiv_resp_t div_resp,
  input  muldiv_pkg::muldiv_resp_t mul_resp,
  output muldiv_pkg::muldiv_req_t  req,
  output logic                     start
);
  import muldiv_pkg::*;

  logic [`MULDIV_XLEN-1:0] a_reg;
  logic [`MULDIV_XLEN-1:0] b_reg;
  muldiv_fn_e              fn_reg;
  logic                    bus_req;
  logic                    wr_en;
  logic                    cmd_ok;
  muldiv_resp_t            res_sel;
  logic [31:0]             rd_data;

  // merge write data into a register, one byte lane per sel bit
  function automatic logic [31:0] lane_merge(input logic [31:0] cur,
                                             input logic [31:0] wdata,
                                             input logic [3:0]  sel);
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  // --------------------------------------------------
  // bus decode
  // --------------------------------------------------

  // ~ack keeps a held stb from being acked twice
  assign bus_req = wb_in.cyc & wb_in.stb & ~wb_out.ack;
  assign wr_en   = bus_req & wb_in.we;

  // command accepted only when idle and no start already in flight
  assign cmd_ok = wr_en && (wb_in.adr == `MULDIV_ADDR_CMD) && !status.busy && !start;

  // result source follows the function of the running/last op
  assign res_sel = (req.fn == FN_MUL || req.fn == FN_MULU) ? mul_resp : div_resp;

  always_comb begin
    case (wb_in.adr)
      `MULDIV_ADDR_A:      rd_data = a_reg;
      `MULDIV_ADDR_B:      rd_data = b_reg;
      `MULDIV_ADDR_CMD:    rd_data = {30'b0, fn_reg};
      `MULDIV_ADDR_STATUS: rd_data = {30'b0, status};
      `MULDIV_ADDR_RES_LO: rd_data = res_sel.lo;
      `MULDIV_ADDR_RES_HI: rd_data = res_sel.hi;
      // unmapped reads return zero
      default:             rd_data = '0;
    endcase
  end

  // --------------------------------------------------
  // registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_out <= '0;
      a_reg  <= '0;
      b_reg  <= '0;
      fn_reg <= FN_DIV;
      start  <= 1'b0;
      req    <= '0;
    end else begin
      // single-cycle ack, read data valid alongside it
      wb_out.ack <= bus_req;
      wb_out.dat <= (bus_req && !wb_in.we) ? rd_data : '0;
      start      <= cmd_ok;

      if (wr_en && wb_in.adr == `MULDIV_ADDR_A) begin
        a_reg <= lane_merge(a_reg, wb_in.dat, wb_in.sel);
      end
      if (wr_en && wb_in.adr == `MULDIV_ADDR_B) begin
        b_reg <= lane_merge(b_reg, wb_in.dat, wb_in.sel);
      end
      // fn sits in the low byte lane
      if (cmd_ok && wb_in.sel[0]) begin
        fn_reg <= muldiv_fn_e'(wb_in.dat[1:0]);
      end

      // snapshot operands so later A/B writes cannot disturb the op
      if (start) begin
        req <= '{fn: fn_reg, a: a_reg, b: b_reg};
      end
    end
  end

  // every ack answers a request seen on the previous edge
  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    wb_out.ack |-> $past(wb_in.cyc && wb_in.stb));

endmodule

`default_nettype wire

// File: hdl/muldiv_ctrl.sv
/*
 * sequencer FSM and iteration counter, steers load/step/fix to one datapath
 */
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  muldiv_pkg::muldiv_fn_e fn,
  output muldiv_pkg::dpath_cmd_t div_cmd,
  output muldiv_pkg::dpath_cmd_t mul_cmd,
  output muldiv_pkg::status_t    status
);
  import muldiv_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    CALC,
    FIX
  } state_e;

  state_e                   state;
  logic [`MULDIV_CNT_W-1:0] cnt;
  logic                     done_q;
  dpath_cmd_t               seq_cmd;
  logic                     is_mul;

  // --------------------------------------------------
  // state and counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IDLE;
      cnt    <= '0;
      done_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // a new op hides the previous done
          if (start) begin
            state  <= LOAD;
            done_q <= 1'b0;
          end
        end
        LOAD: begin
          cnt   <= `MULDIV_CNT_W'(`MULDIV_ITERS - 1);
          state <= CALC;
        end
        CALC: begin
          // last step happens with cnt at zero
          if (cnt == '0) begin
            state <= FIX;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        FIX: begin
          state  <= IDLE;
          done_q <= 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // command decode
  // --------------------------------------------------

  always_comb begin
    seq_cmd      = '0;
    seq_cmd.load = (state == LOAD);
    seq_cmd.step = (state == CALC);
    seq_cmd.fix  = (state == FIX);
  end

  assign is_mul = (fn == FN_MUL) || (fn == FN_MULU);

  // idle datapath sees all zeros
  assign div_cmd = is_mul ? '0 : seq_cmd;
  assign mul_cmd = is_mul ? seq_cmd : '0;

  assign status = '{busy: (state != IDLE), done: done_q};

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  cmd_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0({div_cmd.load, div_cmd.step, div_cmd.fix}) &&
    $onehot0({mul_cmd.load, mul_cmd.step, mul_cmd.fix}));

  cmd_exclusive: assert property (@(posedge clk) disable iff (reset)
    !((div_cmd != '0) && (mul_cmd != '0)));

  // captured request must not move under a running op
  fn_stable: assert property (@(posedge clk) disable iff (reset)
    (status.busy && $past(status.busy)) |-> $stable(fn));

endmodule

`default_nettype wire

// File: hdl/div_dpath.sv
/*
 * restoring shift-subtract divider with sign normalization and sign fix
 */
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_defs.svh"

module div_dpath (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::muldiv_req_t  req,
  input  muldiv_pkg::dpath_cmd_t   cmd,
  output muldiv_pkg::muldiv_resp_t resp
);
  import muldiv_pkg::*;

  // remainder in [2X-1:X], quotient in [X-1:0], top bit catches the borrow
  logic [2*`MULDIV_XLEN:0]   rq;
  logic [`MULDIV_XLEN-1:0]   divisor;
  logic                      q_neg;
  logic                      r_neg;
  logic                      b_zero;
  logic                      is_signed;
  logic [`MULDIV_XLEN-1:0]   a_mag;
  logic [`MULDIV_XLEN-1:0]   b_mag;
  logic [2*`MULDIV_XLEN:0]   shifted;
  logic [2*`MULDIV_XLEN:0]   diff;

  // --------------------------------------------------
  // operand normalization
  // --------------------------------------------------

  assign is_signed = (req.fn == FN_DIV);

  // magnitude of the most negative value is still correct as unsigned
  assign a_mag = (is_signed && req.a[`MULDIV_XLEN-1]) ? (~req.a + 1'b1) : req.a;
  assign b_mag = (is_signed && req.b[`MULDIV_XLEN-1]) ? (~req.b + 1'b1) : req.b;

  // --------------------------------------------------
  // shift and trial subtract
  // --------------------------------------------------

  assign shifted = {rq[2*`MULDIV_XLEN-1:0], 1'b0};
  assign diff    = shifted - {1'b0, divisor, {`MULDIV_XLEN{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      rq     <= '0;
      q_neg  <= 1'b0;
      r_neg  <= 1'b0;
      b_zero <= 1'b0;
    end else if (cmd.load) begin
      rq      <= {{(`MULDIV_XLEN+1){1'b0}}, a_mag};
      divisor <= b_mag;
      q_neg   <= is_signed && (req.a[`MULDIV_XLEN-1] ^ req.b[`MULDIV_XLEN-1]);
      // remainder follows the dividend
      r_neg   <= is_signed && req.a[`MULDIV_XLEN-1];
      b_zero  <= (req.b == '0);
    end else if (cmd.step) begin
      // borrow means restore and shift in 0, else keep and shift in 1
      if (diff[2*`MULDIV_XLEN]) begin
        rq <= shifted;
      end else begin
        rq <= {diff[2*`MULDIV_XLEN:1], 1'b1};
      end
    end else if (cmd.fix) begin
      rq[2*`MULDIV_XLEN] <= 1'b0;
      // div by zero keeps the all-ones quotient
      if (q_neg && !b_zero) begin
        rq[`MULDIV_XLEN-1:0] <= ~rq[`MULDIV_XLEN-1:0] + 1'b1;
      end
      if (r_neg) begin
        rq[2*`MULDIV_XLEN-1:`MULDIV_XLEN] <= ~rq[2*`MULDIV_XLEN-1:`MULDIV_XLEN] + 1'b1;
      end
    end
  end

  assign resp = '{hi: rq[2*`MULDIV_XLEN-1:`MULDIV_XLEN], lo: rq[`MULDIV_XLEN-1:0]};

endmodule

`default_nettype wire

// File: hdl/mul_dpath.sv
/*
 * shift-add multiplier with sign normalization and sign fix
 */
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_defs.svh"

module mul_dpath (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::muldiv_req_t  req,
  input  muldiv_pkg::dpath_cmd_t   cmd,
  output muldiv_pkg::muldiv_resp_t resp
);
  import muldiv_pkg::*;

  // partial product on top, multiplier bits shift out the bottom
  logic [2*`MULDIV_XLEN-1:0] prod;
  logic [`MULDIV_XLEN-1:0]   mcand;
  logic                      p_neg;
  logic                      is_signed;
  logic [`MULDIV_XLEN-1:0]   a_mag;
  logic [`MULDIV_XLEN-1:0]   b_mag;
  logic [`MULDIV_XLEN:0]     sum;

  // --------------------------------------------------
  // operand normalization
  // --------------------------------------------------

  assign is_signed = (req.fn == FN_MUL);
  assign a_mag = (is_signed && req.a[`MULDIV_XLEN-1]) ? (~req.a + 1'b1) : req.a;
  assign b_mag = (is_signed && req.b[`MULDIV_XLEN-1]) ? (~req.b + 1'b1) : req.b;

  // add the multiplicand when the current multiplier bit is set
  // carry kept in the extra bit, it shifts back into the product
  assign sum = {1'b0, prod[2*`MULDIV_XLEN-1:`MULDIV_XLEN]} +
               (prod[0] ? {1'b0, mcand} : {(`MULDIV_XLEN+1){1'b0}});

  always_ff @(posedge clk) begin
    if (reset) begin
      prod  <= '0;
      p_neg <= 1'b0;
    end else if (cmd.load) begin
      prod  <= {{`MULDIV_XLEN{1'b0}}, b_mag};
      mcand <= a_mag;
      p_neg <= is_signed && (req.a[`MULDIV_XLEN-1] ^ req.b[`MULDIV_XLEN-1]);
    end else if (cmd.step) begin
      prod <= {sum, prod[`MULDIV_XLEN-1:1]};
    end else if (cmd.fix) begin
      // two's complement over the full 64 bits
      if (p_neg) begin
        prod <= ~prod + 1'b1;
      end
    end
  end

  assign resp = '{hi: prod[2*`MULDIV_XLEN-1:`MULDIV_XLEN], lo: prod[`MULDIV_XLEN-1:0]};

endmodule

`default_nettype wire

// File: hdl/muldiv_top.sv
/*
 * multiply/divide unit top: register block, sequencer, both datapaths
 */
`timescale 1ns/100ps
`default_nettype none

module muldiv_top (
  input  logic                clk,
  input  logic                reset,
  input  muldiv_pkg::wb_m2s_t wb_in,
  output muldiv_pkg::wb_s2m_t wb_out
);
  import muldiv_pkg::*;

  muldiv_req_t  req;
  logic         start;
  status_t      status;
  dpath_cmd_t   div_cmd;
  dpath_cmd_t   mul_cmd;
  muldiv_resp_t div_resp;
  muldiv_resp_t mul_resp;

  // host side, also picks which result is read back
  muldiv_wb_regs regs_i (
    .clk      (clk),
    .reset    (reset),
    .wb_in    (wb_in),
    .wb_out   (wb_out),
    .status   (status),
    .div_resp (div_resp),
    .mul_resp (mul_resp),
    .req      (req),
    .start    (start)
  );

  muldiv_ctrl ctrl_i (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .fn      (req.fn),
    .div_cmd (div_cmd),
    .mul_cmd (mul_cmd),
    .status  (status)
  );

  // both datapaths see the same request, only one gets strobes
  div_dpath div_i (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .cmd   (div_cmd),
    .resp  (div_resp)
  );

  mul_dpath mul_i (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .cmd   (mul_cmd),
    .resp  (mul_resp)
  );

endmodule

`default_nettype wire

// File: verification/muldiv_tb.sv
/*
 * directed testbench for the multiply/divide unit: wishbone bus tasks,
 * reference model, compare tasks, timeout and the six directed tests
 */
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_tb;
  import muldiv_pkg::*;

  // ~70 ops at ~50 cycles each is ~3500, rounded up with a wide margin
  localparam int MAX_CYCLES = 20000;

  logic    clk;
  logic    reset;
  wb_m2s_t wb_in;
  wb_s2m_t wb_out;
  int      cycle_cnt;
  int      err_cnt;
  int      check_cnt;
  int      test_cnt;
  integer  seed;

  muldiv_top dut_i (
    .clk    (clk),
    .reset  (reset),
    .wb_in  (wb_in),
    .wb_out (wb_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog, ends the run if the tests stall
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  // --------------------------------------------------
  // wishbone classic bus tasks
  // --------------------------------------------------

  // one classic cycle, request held until ack, dropped on the next edge
  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic [31:0] rdata);
    wb_m2s_t m;
    m     = '0;
    m.cyc = 1'b1;
    m.stb = 1'b1;
    m.we  = we;
    m.adr = adr;
    m.dat = dat;
    m.sel = sel;
    @(posedge clk);
    wb_in <= m;
    // sample mid-cycle, away from the edge the DUT updates on
    @(negedge clk);
    while (!wb_out.ack) @(negedge clk);
    rdata = wb_out.dat;
    @(posedge clk);
    wb_in <= '0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
    bus_cycle(1'b0, adr, 32'h0, 4'hf, dat);
  endtask

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input muldiv_resp_t got, input muldiv_resp_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %s: got hi 0x%08h lo 0x%08h, expected hi 0x%08h lo 0x%08h",
               name, got.hi, got.lo, exp.hi, exp.lo);
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR status: got 0x%0h, expected 0x%0h", got, exp);
    end
  endtask

  // --------------------------------------------------
  // reference model and op helpers
  // --------------------------------------------------

  // div: hi remainder, lo quotient, x/0 gives all ones and remainder a
  task automatic model_result(input muldiv_fn_e fn, input logic [31:0] a, input logic [31:0] b,
                              output muldiv_resp_t exp);
    longint      sa;
    longint      sb;
    longint      q;
    longint      r;
    logic [63:0] p;
    sa  = longint'($signed(a));
    sb  = longint'($signed(b));
    exp = '0;
    if ((fn == FN_DIV || fn == FN_DIVU) && b == 32'h0) begin
      exp.hi = a;
      exp.lo = 32'hffff_ffff;
    end else if (fn == FN_DIVU) begin
      exp.lo = a / b;
      exp.hi = a % b;
    end else if (fn == FN_DIV) begin
      // 64-bit math so -2^31 / -1 wraps to 0x80000000
      q      = sa / sb;
      r      = sa % sb;
      exp.lo = q[31:0];
      exp.hi = r[31:0];
    end else if (fn == FN_MULU) begin
      p   = {32'h0, a} * {32'h0, b};
      exp = p;
    end else begin
      p   = sa * sb;
      exp = p;
    end
  endtask

  // write operands and command, poll until done, read both result words
  task automatic run_op(input muldiv_fn_e fn, input logic [31:0] a, input logic [31:0] b,
                        output muldiv_resp_t got, output bit saw_busy);
    logic [31:0] w;
    status_t     st;
    saw_busy = 1'b0;
    wb_write(`MULDIV_ADDR_A, a, 4'hf);
    wb_write(`MULDIV_ADDR_B, b, 4'hf);
    wb_write(`MULDIV_ADDR_CMD, {30'h0, fn}, 4'hf);
    do begin
      wb_read(`MULDIV_ADDR_STATUS, w);
      st = w[1:0];
      if (st.busy) begin
        saw_busy = 1'b1;
      end
    end while (!st.done);
    wb_read(`MULDIV_ADDR_RES_LO, w);
    got.lo = w;
    wb_read(`MULDIV_ADDR_RES_HI, w);
    got.hi = w;
  endtask

  task automatic check_op(input muldiv_fn_e fn, input logic [31:0] a, input logic [31:0] b,
                          output bit saw_busy);
    muldiv_resp_t got;
    muldiv_resp_t exp;
    run_op(fn, a, b, got, saw_busy);
    model_result(fn, a, b, exp);
    check_resp($sformatf("result fn %0d a 0x%08h b 0x%08h", fn, a, b), got, exp);
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    $display("test %s finished with %0d error(s)", name, err_cnt - err_before);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------

  task automatic test_reset_state();
    int          e0;
    logic [31:0] w;
    e0 = err_cnt;
    wb_read(`MULDIV_ADDR_STATUS, w);
    check_status(w[1:0], 2'b00);
    wb_read(`MULDIV_ADDR_RES_LO, w);
    check_word("res_lo", w, 32'h0);
    wb_read(`MULDIV_ADDR_RES_HI, w);
    check_word("res_hi", w, 32'h0);
    wb_read(`MULDIV_ADDR_A, w);
    check_word("reg_a", w, 32'h0);
    // hole in the map
    wb_read(8'h20, w);
    check_word("unmapped", w, 32'h0);
    // byte lanes 0 and 2 on A, lanes 1 and 3 on B
    wb_write(`MULDIV_ADDR_A, 32'h1122_3344, 4'hf);
    wb_write(`MULDIV_ADDR_A, 32'haabb_ccdd, 4'b0101);
    wb_read(`MULDIV_ADDR_A, w);
    check_word("reg_a", w, 32'h11bb_33dd);
    wb_write(`MULDIV_ADDR_B, 32'h5566_7788, 4'hf);
    wb_write(`MULDIV_ADDR_B, 32'heeff_0099, 4'b1010);
    wb_read(`MULDIV_ADDR_B, w);
    check_word("reg_b", w, 32'hee66_0088);
    report_test("reset_and_byte_lanes", e0);
  endtask

  task automatic test_divu();
    int          e0;
    bit          sb;
    bit          any_busy;
    logic [31:0] a;
    logic [31:0] b;
    e0       = err_cnt;
    any_busy = 1'b0;
    check_op(FN_DIVU, 32'd100, 32'd7, sb);
    any_busy |= sb;
    check_op(FN_DIVU, 32'd7, 32'd100, sb);
    check_op(FN_DIVU, 32'hffff_ffff, 32'd1, sb);
    check_op(FN_DIVU, 32'hffff_ffff, 32'hffff_ffff, sb);
    check_op(FN_DIVU, 32'h8000_0000, 32'd3, sb);
    check_op(FN_DIVU, 32'd0, 32'd5, sb);
    // shrink the divisor so quotients cover many widths
    for (int i = 0; i < 16; i++) begin
      a = $random(seed);
      b = $unsigned($random(seed)) >> (i + 4);
      check_op(FN_DIVU, a, b, sb);
      any_busy |= sb;
    end
    if (!any_busy) begin
      err_cnt++;
      $display("status never read busy while an unsigned division was running");
    end
    report_test("unsigned_div", e0);
  endtask

  task automatic test_div_signed();
    int           e0;
    bit           sb;
    logic [31:0]  a;
    logic [31:0]  b;
    muldiv_resp_t got;
    muldiv_resp_t exp;
    e0 = err_cnt;
    check_op(FN_DIV, 32'd100, 32'd7, sb);
    check_op(FN_DIV, -32'sd100, 32'd7, sb);
    check_op(FN_DIV, 32'd100, -32'sd7, sb);
    check_op(FN_DIV, -32'sd100, -32'sd7, sb);
    // remainder follows the sign of a
    run_op(FN_DIV, -32'sd100, 32'd7, got, sb);
    exp.hi = 32'hffff_fffe;
    exp.lo = 32'hffff_fff2;
    check_resp("neg_dividend_result", got, exp);
    // the one signed overflow case
    run_op(FN_DIV, 32'h8000_0000, 32'hffff_ffff, got, sb);
    exp.hi = 32'h0;
    exp.lo = 32'h8000_0000;
    check_resp("overflow_result", got, exp);
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      b = $random(seed) >>> (i + 8);
      check_op(FN_DIV, a, b, sb);
    end
    report_test("signed_div", e0);
  endtask

  task automatic test_div_zero();
    int           e0;
    bit           sb;
    logic [31:0]  avals [4];
    muldiv_resp_t got;
    muldiv_resp_t exp;
    e0       = err_cnt;
    avals[0] = 32'd12345;
    avals[1] = 32'h8000_0000;
    avals[2] = 32'hffff_fffb;
    avals[3] = 32'h0;
    for (int k = 0; k < 8; k++) begin
      run_op(k[0] ? FN_DIVU : FN_DIV, avals[k >> 1], 32'h0, got, sb);
      exp.hi = avals[k >> 1];
      exp.lo = 32'hffff_ffff;
      check_resp($sformatf("div_by_zero_result a 0x%08h", avals[k >> 1]), got, exp);
    end
    report_test("div_by_zero", e0);
  endtask

  task automatic test_mul();
    int          e0;
    bit          sb;
    logic [31:0] ca [5];
    logic [31:0] cb [5];
    logic [31:0] a;
    logic [31:0] b;
    e0    = err_cnt;
    ca[0] = 32'h0;
    cb[0] = 32'hdead_beef;
    ca[1] = 32'h1;
    cb[1] = 32'hffff_ffff;
    ca[2] = 32'hffff_ffff;
    cb[2] = 32'hffff_ffff;
    ca[3] = 32'h8000_0000;
    cb[3] = 32'h8000_0000;
    ca[4] = 32'h7fff_ffff;
    cb[4] = 32'h8000_0000;
    for (int k = 0; k < 5; k++) begin
      check_op(FN_MUL, ca[k], cb[k], sb);
      check_op(FN_MULU, ca[k], cb[k], sb);
    end
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      b = $random(seed);
      check_op(FN_MUL, a, b, sb);
      check_op(FN_MULU, a, b, sb);
    end
    report_test("multiply", e0);
  endtask

  task automatic test_busy_cmd();
    int           e0;
    logic [31:0]  w;
    status_t      st;
    muldiv_resp_t got;
    muldiv_resp_t exp;
    e0 = err_cnt;
    wb_write(`MULDIV_ADDR_A, 32'd1000, 4'hf);
    wb_write(`MULDIV_ADDR_B, 32'd7, 4'hf);
    wb_write(`MULDIV_ADDR_CMD, {30'h0, FN_DIVU}, 4'hf);
    // second command lands while the first is still iterating
    wb_write(`MULDIV_ADDR_A, 32'd5, 4'hf);
    wb_write(`MULDIV_ADDR_B, 32'd3, 4'hf);
    wb_write(`MULDIV_ADDR_CMD, {30'h0, FN_MULU}, 4'hf);
    do begin
      wb_read(`MULDIV_ADDR_STATUS, w);
      st = w[1:0];
    end while (!st.done);
    wb_read(`MULDIV_ADDR_RES_LO, w);
    got.lo = w;
    wb_read(`MULDIV_ADDR_RES_HI, w);
    got.hi = w;
    model_result(FN_DIVU, 32'd1000, 32'd7, exp);
    check_resp("ignored_cmd_result", got, exp);
    // a second run would show busy again within 34 cycles
    for (int i = 0; i < 15; i++) begin
      wb_read(`MULDIV_ADDR_STATUS, w);
      check_status(w[1:0], 2'b01);
    end
    report_test("cmd_while_busy", e0);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    seed      = 32'hca03;
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    reset     = 1'b1;
    wb_in     = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_divu();
    test_div_signed();
    test_div_zero();
    test_mul();
    test_busy_cmd();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/muldiv_pkg.sv
hdl/muldiv_wb_regs.sv
hdl/muldiv_ctrl.sv
hdl/div_dpath.sv
hdl/mul_dpath.sv
hdl/muldiv_top.sv
verification/muldiv_tb.sv

// File: Bender.yml
package:
  name: muldiv

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/muldiv_pkg.sv
      - hdl/muldiv_wb_regs.sv
      - hdl/muldiv_ctrl.sv
      - hdl/div_dpath.sv
      - hdl/mul_dpath.sv
      - hdl/muldiv_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/muldiv_tb.sv
